// File: files.f
logic/display_ctrl_pkg.sv
logic/display_geom_pkg.sv
logic/frame_latch.sv
logic/scan_counter.sv
logic/brightness_pwm.sv
logic/charlieplexer.sv
logic/charlieplex_top.sv
dv/charlieplex_checker.sv
dv/charlieplex_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the charlieplexed display testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
TOP=charlieplex_tb

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module "$TOP" -Mdir "$BUILD_DIR"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
	echo "Simulation passed, log in $LOG"
	exit 0
else
	echo "Simulation failed, log in $LOG"
	exit 1
fi

// File: dv/charlieplex_tb.sv
// Testbench top for the charlieplexed display; sends LFSR-driven host frames and checks the pins.
`timescale 1ns/1ps

module charlieplex_tb;

	localparam int DWELL       = 2; // Cycles per pixel in the DUT.
	localparam int FRAME_COUNT = 40; // Host frames sent.
	localparam int PASS_CYCLES = display_geom_pkg::PIXELCOUNT * DWELL; // One scan pass.
	localparam int CYCLE_LIMIT = FRAME_COUNT * 7 * PASS_CYCLES + 1000; // Margin for reset and tail.
	localparam logic [15:0] LFSR_SEED = 16'd41796;
	localparam logic [15:0] LFSR_TAPS = 16'hB400; // x^16+x^14+x^13+x^11+1.

	logic                         pixelclock;
	logic                         rst;
	logic                         enable;
	logic                         in_valid;
	logic                         in_ready;
	display_geom_pkg::frame_t     in_frame;
	display_geom_pkg::pin_drive_t pins;
	logic [15:0]                  lfsr_state; // Stimulus generator state.
	int                           cycle_count = 0;
	int                           error_count;
	int                           check_count;

	charlieplex_top #(
		.DWELL (DWELL)
	) UUT (
		.pixelclock (pixelclock),
		.rst        (rst),
		.enable     (enable),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_frame   (in_frame),
		.pins       (pins)
	);

	charlieplex_checker #(
		.DWELL (DWELL)
	) u_checker (
		.pixelclock  (pixelclock),
		.rst         (rst),
		.enable      (enable),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_frame    (in_frame),
		.pins        (pins),
		.error_count (error_count),
		.check_count (check_count)
	);

	initial begin
		pixelclock = 1'b0;
		forever #4 pixelclock = ~pixelclock; // 8 ns period.
	end

	always @(posedge pixelclock) begin
		cycle_count <= cycle_count + 1;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ LFSR_TAPS;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit taken, bits shift in from the bottom.
	task automatic rand_bits(input int count, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits       = {bits[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Advance to the next falling edge; enable drops now and then.
	task automatic next_cycle();
		logic [15:0] bits;
		@(negedge pixelclock);
		rand_bits(4, bits);
		enable = (bits[3:0] != 4'd0); // Low about one cycle in sixteen.
	endtask

	// Present a random frame and hold it until the DUT takes it.
	task automatic send_frame();
		logic [15:0] bits;
		logic        ready_seen;
		rand_bits(1, bits);
		in_frame.op = bits[0] ? display_ctrl_pkg::OP_LEVEL : display_ctrl_pkg::OP_FRAME;
		rand_bits(12, bits);
		in_frame.pixels = bits[11:0];
		rand_bits(3, bits);
		in_frame.level = bits[2:0];
		in_valid       = 1'b1;
		ready_seen     = in_ready; // Ready for the coming rising edge.
		while (!ready_seen) begin
			next_cycle();
			ready_seen = in_ready;
		end
		next_cycle(); // Transfer happened on the edge just passed.
	endtask

	initial begin
		logic [15:0] bits;
		lfsr_state = LFSR_SEED;
		rst        = 1'b1;
		enable     = 1'b1;
		in_valid   = 1'b0;
		in_frame   = '0;
		repeat (5) @(negedge pixelclock); // Five reset edges.
		rst = 1'b0;
		repeat (PASS_CYCLES) next_cycle(); // Dark pass, ready high.
		for (int f = 0; f < FRAME_COUNT; f++) begin
			send_frame();
			rand_bits(3, bits);
			if (bits[2:0] != 3'd0) begin
				in_valid = 1'b0; // Host pauses, otherwise the next frame follows at once.
			end
			repeat (int'(bits[2:0]) * 8) next_cycle();
		end
		in_valid = 1'b0;
		while (!in_ready) begin
			next_cycle(); // Last frame reaches the display.
		end
		repeat (7 * PASS_CYCLES + 2) next_cycle(); // Full brightness cycle on the last frame.
		$display("Checks: %0d, errors: %0d, cycles: %0d", check_count, error_count, cycle_count);
		if (error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Run limit from the frame count, hit only when the stimulus stalls.
	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge pixelclock);
		end
		$display("Timeout: the run hung and did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Checks: %0d, errors: %0d, cycles: %0d", check_count, error_count, cycle_count);
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: dv/charlieplex_checker.sv
// Reference model of the display; follows the host port and compares pins and in_ready every cycle.
`timescale 1ns/1ps

module charlieplex_checker #(
	parameter int DWELL = 1 // Same value as the DUT.
) (
	input  logic                         pixelclock,
	input  logic                         rst,
	input  logic                         enable,
	input  logic                         in_valid,
	input  logic                         in_ready,
	input  display_geom_pkg::frame_t     in_frame,
	input  display_geom_pkg::pin_drive_t pins,
	output int                           error_count,
	output int                           check_count
);

	localparam int PASSES = 7; // Brightness duty steps.

	logic                                    m_valid; // Model has seen a reset edge.
	display_ctrl_pkg::latch_state_e          m_state; // Model latch slot.
	display_geom_pkg::frame_t                m_pending;
	logic [display_geom_pkg::PIXELCOUNT-1:0] m_pixels; // Shown bitmap.
	logic [display_geom_pkg::LEVEL_BITS-1:0] m_level; // Shown level.
	int                                      m_dwell; // Cycles spent on the pixel.
	int                                      m_index; // Pixel being scanned.
	int                                      m_pass; // Pass count, 0 to 6.
	display_geom_pkg::pin_drive_t            m_pins; // Expected pins after the last edge.

	initial begin
		m_valid     = 1'b0;
		error_count = 0;
		check_count = 0;
	end

	// Pixel i sources from pin i/3 and sinks into one of the other three.
	function automatic display_geom_pkg::pin_drive_t pin_pair_for(input int index);
		display_geom_pkg::pin_drive_t drive;
		int                           high_pin;
		int                           low_pin;
		high_pin = index / 3;
		low_pin  = index % 3;
		if (low_pin >= high_pin) begin
			low_pin = low_pin + 1; // Skip over the high pin.
		end
		drive              = '0;
		drive.en[high_pin] = 1'b1;
		drive.en[low_pin]  = 1'b1;
		drive.value[high_pin] = 1'b1; // Partner pin driven low.
		return drive;
	endfunction

	task automatic report_mismatch(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		error_count++;
		$display("ERROR t=%0t %s expected %h actual %h", $time, name, expected, actual);
	endtask

	// Model steps on the rising edge with the inputs the host set up at the falling edge.
	always @(posedge pixelclock) begin : model_step
		logic pass_end;
		logic lit;
		pass_end = (m_dwell == DWELL - 1) && (m_index == display_geom_pkg::PIXELCOUNT - 1);
		if (rst) begin
			m_valid  = 1'b1;
			m_state  = display_ctrl_pkg::LATCH_EMPTY; // Ready after reset.
			m_pixels = '0;
			m_level  = '0;
			m_dwell  = 0;
			m_index  = 0;
			m_pass   = 0;
			m_pins   = '0; // All pins tristate.
		end else if (m_valid) begin
			lit = m_pixels[m_index] && enable &&
				((int'(m_level) == 7) || (m_pass < int'(m_level)));
			m_pins = lit ? pin_pair_for(m_index) : '0; // Registered, seen one cycle later.
			if (m_state == display_ctrl_pkg::LATCH_EMPTY) begin
				if (in_valid) begin
					m_pending = in_frame; // Transfer on this edge.
					m_state   = display_ctrl_pkg::LATCH_FULL;
				end
			end else if (pass_end) begin
				m_level = m_pending.level; // Swap at the pass boundary.
				if (m_pending.op == display_ctrl_pkg::OP_FRAME) begin
					m_pixels = m_pending.pixels;
				end
				m_state = display_ctrl_pkg::LATCH_EMPTY;
			end
			if (pass_end) begin
				m_pass = (m_pass == PASSES - 1) ? 0 : m_pass + 1;
			end
			if (m_dwell == DWELL - 1) begin
				m_dwell = 0;
				m_index = (m_index == display_geom_pkg::PIXELCOUNT - 1) ? 0 : m_index + 1;
			end else begin
				m_dwell = m_dwell + 1; // Hold the pixel.
			end
		end
	end

	// Outputs settle well before the falling edge.
	always @(negedge pixelclock) begin
		if (m_valid) begin
			check_count++;
			if (pins.en !== m_pins.en) begin
				report_mismatch("pins.en", 8'(m_pins.en), 8'(pins.en));
			end
			if (pins.value !== m_pins.value) begin
				report_mismatch("pins.value", 8'(m_pins.value), 8'(pins.value));
			end
			if (in_ready !== (m_state == display_ctrl_pkg::LATCH_EMPTY)) begin
				report_mismatch("in_ready", 8'(m_state == display_ctrl_pkg::LATCH_EMPTY),
					8'(in_ready));
			end
		end
	end

endmodule

// File: logic/charlieplex_top.sv
// Top level of the charlieplexed display; connects frame latch, scanner, modulator and pin decoder.
`timescale 1ns/1ps

module charlieplex_top #(
	parameter int DWELL = 1 // Cycles per pixel, passed to the scanner.
) (
	input  logic                         pixelclock,
	input  logic                         rst,
	input  logic                         enable,
	input  logic                         in_valid,
	output logic                         in_ready,
	input  display_geom_pkg::frame_t     in_frame,
	output display_geom_pkg::pin_drive_t pins
);

	logic [display_geom_pkg::PIXELCOUNT-1:0] shown_pixels; // Image on display.
	logic [display_geom_pkg::LEVEL_BITS-1:0] shown_level;
	logic [display_geom_pkg::INDEX_BITS-1:0] pixel_index; // Pixel being scanned.
	logic                                    pixel_lit;
	logic                                    pass_end; // Last cycle of a pass.
	logic                                    pass_lit; // Pass gated on by brightness.

	// Host frame holder, swaps at pass ends.
	frame_latch u_frame_latch (
		.pixelclock   (pixelclock),
		.rst          (rst),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_frame     (in_frame),
		.pass_end     (pass_end),
		.shown_pixels (shown_pixels),
		.shown_level  (shown_level)
	);

	// Pixel walk.
	scan_counter #(
		.DWELL (DWELL)
	) u_scan_counter (
		.pixelclock   (pixelclock),
		.rst          (rst),
		.shown_pixels (shown_pixels),
		.pixel_index  (pixel_index),
		.pixel_lit    (pixel_lit),
		.pass_end     (pass_end)
	);

	// Pass gating by level.
	brightness_pwm u_brightness_pwm (
		.pixelclock  (pixelclock),
		.rst         (rst),
		.shown_level (shown_level),
		.pass_end    (pass_end),
		.pass_lit    (pass_lit)
	);

	// Pin drive register.
	charlieplexer u_charlieplexer (
		.pixelclock  (pixelclock),
		.rst         (rst),
		.pixel_index (pixel_index),
		.pixel_lit   (pixel_lit),
		.pass_lit    (pass_lit),
		.enable      (enable),
		.pins        (pins)
	);

endmodule

// File: logic/charlieplexer.sv
// Decodes the pixel index into one high pin and one low pin and registers the pin drive.
`timescale 1ns/1ps

module charlieplexer (
	input  logic                                    pixelclock,
	input  logic                                    rst,
	input  logic [display_geom_pkg::INDEX_BITS-1:0] pixel_index,
	input  logic                                    pixel_lit,
	input  logic                                    pass_lit,
	input  logic                                    enable,
	output display_geom_pkg::pin_drive_t            pins
);

	logic                                    lit; // All three lit conditions.
	logic [display_geom_pkg::INDEX_BITS-1:0] group; // Index div 3, the high pin.
	logic [display_geom_pkg::INDEX_BITS-1:0] slot; // Index mod 3.
	logic [display_geom_pkg::INDEX_BITS-1:0] low_sel; // Slot skipping the high pin.
	logic [display_geom_pkg::PIN_BITS-1:0]   pin_hi;
	logic [display_geom_pkg::PIN_BITS-1:0]   pin_lo;
	logic [display_geom_pkg::PINCOUNT-1:0]   hi_mask; // One-hot high pin.
	logic [display_geom_pkg::PINCOUNT-1:0]   lo_mask; // One-hot low pin.
	display_geom_pkg::pin_drive_t            drive_next;

	assign lit = pixel_lit && pass_lit && enable;

	// Pixel i: high pin i/3, low pin from the remaining three.
	assign group   = pixel_index / display_geom_pkg::GROUP_SIZE;
	assign slot    = pixel_index % display_geom_pkg::GROUP_SIZE;
	assign low_sel = (slot < group) ? slot : slot + 1'b1; // Step over the high pin.
	assign pin_hi  = group[display_geom_pkg::PIN_BITS-1:0];
	assign pin_lo  = low_sel[display_geom_pkg::PIN_BITS-1:0];

	assign hi_mask = display_geom_pkg::PIN_ONE << pin_hi;
	assign lo_mask = display_geom_pkg::PIN_ONE << pin_lo;

	// Off pixels tristate every pin.
	always_comb begin
		drive_next.en    = '0;
		drive_next.value = '0;
		if (lit) begin
			drive_next.en    = hi_mask | lo_mask;
			drive_next.value = hi_mask; // Low pin driven to GND.
		end
	end

	// Pins lag the index by one cycle.
	always_ff @(posedge pixelclock) begin
		if (rst) begin
			pins <= '0;
		end else begin
			pins <= drive_next;
		end
	end

	// A lit LED needs a pin pair, never a single or third pin.
	a_en_pair: assert property (@(posedge pixelclock) disable iff (rst)
		($countones(pins.en) == 0) || ($countones(pins.en) == 2));

	// Exactly one driven pin sources the current.
	a_one_high: assert property (@(posedge pixelclock) disable iff (rst)
		(pins.en != '0) |-> $onehot(pins.en & pins.value));

endmodule

// File: logic/brightness_pwm.sv
// Gates whole scan passes by brightness level with a modulo-7 pass counter.
`timescale 1ns/1ps

module brightness_pwm (
	input  logic                                    pixelclock,
	input  logic                                    rst,
	input  logic [display_geom_pkg::LEVEL_BITS-1:0] shown_level,
	input  logic                                    pass_end,
	output logic                                    pass_lit
);

	logic [display_geom_pkg::LEVEL_BITS-1:0] pass_count; // 0..6, one step per pass.
	logic                                    count_wrap; // Last pass of the cycle.

	assign count_wrap = (pass_count == display_geom_pkg::PASS_LAST);

	// Advances only at pass boundaries, so a pass is lit or dark as a whole.
	always_ff @(posedge pixelclock) begin
		if (rst) begin
			pass_count <= '0;
		end else if (pass_end) begin
			if (count_wrap) begin
				pass_count <= '0;
			end else begin
				pass_count <= pass_count + 1'b1;
			end
		end
	end

	// Level L lights L of 7 passes; full level lights all.
	assign pass_lit = (shown_level == display_geom_pkg::LEVEL_FULL) ||
		(pass_count < shown_level);

endmodule

// File: logic/scan_counter.sv
// Walks the pixel index with a dwell count, shifts the shown bitmap and flags each pass end.
`timescale 1ns/1ps

module scan_counter #(
	parameter int DWELL = 1 // Cycles each pixel is held.
) (
	input  logic                                    pixelclock,
	input  logic                                    rst,
	input  logic [display_geom_pkg::PIXELCOUNT-1:0] shown_pixels,
	output logic [display_geom_pkg::INDEX_BITS-1:0] pixel_index,
	output logic                                    pixel_lit,
	output logic                                    pass_end
);

	localparam int DWELL_BITS = (DWELL > 1) ? $clog2(DWELL) : 1; // At least one bit.
	localparam logic [DWELL_BITS-1:0] DWELL_LAST = DWELL_BITS'(DWELL - 1);

	logic [DWELL_BITS-1:0]                   dwell_count; // Cycles spent on this pixel.
	logic [display_geom_pkg::PIXELCOUNT-1:0] shift_pixels; // Bitmap, pixel in use at bit 0.
	logic                                    dwell_done; // Last cycle of this pixel.
	logic                                    first_pixel; // Index 0 of a pass.

	assign dwell_done  = (dwell_count == DWELL_LAST);
	assign first_pixel = (pixel_index == '0);
	assign pass_end    = dwell_done && (pixel_index == display_geom_pkg::LAST_PIXEL);

	// Pixel 0 is read live so a swap at the boundary shows from the first pixel on.
	assign pixel_lit = first_pixel ? shown_pixels[0] : shift_pixels[0];

	// Dwell counter, wraps on every pixel.
	always_ff @(posedge pixelclock) begin
		if (rst) begin
			dwell_count <= '0;
		end else if (dwell_done) begin
			dwell_count <= '0;
		end else begin
			dwell_count <= dwell_count + 1'b1;
		end
	end

	// Index and bitmap copy step together.
	always_ff @(posedge pixelclock) begin
		if (rst) begin
			pixel_index  <= '0;
			shift_pixels <= '0;
		end else if (dwell_done) begin
			if (pass_end) begin
				pixel_index <= '0; // Wrap to start of next pass.
			end else begin
				pixel_index <= pixel_index + 1'b1;
			end
			if (first_pixel) begin
				shift_pixels <= shown_pixels >> 1; // Reload, pixel 1 next.
			end else begin
				shift_pixels <= shift_pixels >> 1;
			end
		end
	end

	// Index never leaves the array.
	a_index_range: assert property (@(posedge pixelclock) disable iff (rst)
		pixel_index < display_geom_pkg::LAST_PIXEL + 1'b1);

endmodule

// File: logic/frame_latch.sv
// Holds one host frame from the valid/ready port and swaps it into the shown image at a pass end.
`timescale 1ns/1ps

module frame_latch (
	input  logic                                    pixelclock,
	input  logic                                    rst,
	input  logic                                    in_valid,
	output logic                                    in_ready,
	input  display_geom_pkg::frame_t                in_frame,
	input  logic                                    pass_end,
	output logic [display_geom_pkg::PIXELCOUNT-1:0] shown_pixels,
	output logic [display_geom_pkg::LEVEL_BITS-1:0] shown_level
);

	display_ctrl_pkg::latch_state_e state; // Pending slot occupancy.
	display_geom_pkg::frame_t       pending; // Frame waiting for the boundary.
	logic                           take; // Host transfer this cycle.
	logic                           swap; // Apply pending frame this cycle.

	assign in_ready = (state == display_ctrl_pkg::LATCH_EMPTY); // Only an empty slot accepts.
	assign take     = in_valid && in_ready;
	assign swap     = (state == display_ctrl_pkg::LATCH_FULL) && pass_end; // Last cycle of pass.

	// Two-state slot control.
	always_ff @(posedge pixelclock) begin
		if (rst) begin
			state <= display_ctrl_pkg::LATCH_EMPTY;
		end else if (take) begin
			state <= display_ctrl_pkg::LATCH_FULL; // Busy from the next cycle.
		end else if (swap) begin
			state <= display_ctrl_pkg::LATCH_EMPTY; // Ready again with the new image.
		end
	end

	// Payload capture, only written on a transfer.
	always_ff @(posedge pixelclock) begin
		if (take) begin
			pending <= in_frame;
		end
	end

	// Shown image changes only between passes, never torn.
	always_ff @(posedge pixelclock) begin
		if (rst) begin
			shown_pixels <= '0;
			shown_level  <= '0; // Dark after reset.
		end else if (swap) begin
			shown_level <= pending.level; // Both opcodes carry a level.
			if (pending.op == display_ctrl_pkg::OP_FRAME) begin
				shown_pixels <= pending.pixels; // OP_LEVEL keeps the bitmap.
			end
		end
	end

	// Host port reopens only on the cycle after a pass end.
	a_ready_after_pass_end: assert property (@(posedge pixelclock) disable iff (rst)
		$rose(in_ready) |-> $past(pass_end));

	// The waiting frame is not overwritten before it is shown.
	a_pending_stable: assert property (@(posedge pixelclock) disable iff (rst)
		(state == display_ctrl_pkg::LATCH_FULL) |=> $stable(pending));

endmodule

// File: logic/display_geom_pkg.sv
// Geometry of the twelve-pixel charlieplexed array and the structs for host frames and pin drives.
package display_geom_pkg;

	localparam int PIXELCOUNT = 12; // Pixels in the array.
	localparam int PINCOUNT   = 4;  // Tristate pins, PINCOUNT*(PINCOUNT-1) pixels.
	localparam int INDEX_BITS = 4;  // Pixel index width.
	localparam int LEVEL_BITS = 3;  // Brightness level width.
	localparam int PIN_BITS   = 2;  // Pin number width.

	// Index of the last pixel in a pass.
	localparam logic [INDEX_BITS-1:0] LAST_PIXEL = INDEX_BITS'(PIXELCOUNT - 1);
	// Pixels sharing one high pin.
	localparam logic [INDEX_BITS-1:0] GROUP_SIZE = INDEX_BITS'(PINCOUNT - 1);
	localparam logic [LEVEL_BITS-1:0] LEVEL_FULL = '1;                // Always lit.
	localparam logic [LEVEL_BITS-1:0] PASS_LAST  = LEVEL_FULL - 1'b1; // Modulo-7 pass count.
	// Single pin mask, shifted to the pin in use.
	localparam logic [PINCOUNT-1:0]   PIN_ONE    = {{(PINCOUNT - 1){1'b0}}, 1'b1};

	// Host frame; bit 0 of pixels is pixel 0.
	typedef struct packed {
		display_ctrl_pkg::frame_op_e  op;
		logic [PIXELCOUNT-1:0]        pixels;
		logic [LEVEL_BITS-1:0]        level;
	} frame_t;

	// Drive for the pins; en=0 means tristate.
	typedef struct packed {
		logic [PINCOUNT-1:0] en;    // Pin is driven.
		logic [PINCOUNT-1:0] value; // 1=VCC, 0=GND when driven.
	} pin_drive_t;

endpackage

// File: logic/display_ctrl_pkg.sv
// Control encodings for the LED display: host frame opcodes and the frame latch states.
package display_ctrl_pkg;

	// Opcode carried in every host frame.
	typedef enum logic [1:0] {
		OP_FRAME = 2'd0, // Replace bitmap and level.
		OP_LEVEL = 2'd1  // Replace level, keep bitmap.
	} frame_op_e;

	// Pending-frame holder of the frame latch.
	typedef enum logic {
		LATCH_EMPTY = 1'b0, // Ready for a host write.
		LATCH_FULL  = 1'b1  // Frame waits for the pass boundary.
	} latch_state_e;

endpackage
